/* filelist.f */
design/ice51_pkg.sv
design/exec_if.sv
design/uart_rx_loader.sv
design/uart_tx.sv
design/cpu_sequencer.sv
design/cpu_datapath.sv
design/ice51_top.sv
verification/tb_ice51.sv

/* run.sh */
#!/bin/sh
# build and run the ice51 testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module tb_ice51 -f filelist.f -o tb_ice51 \
   && ./obj_dir/tb_ice51 | tee sim.log \
   || exit 1

grep -q '>>> FAIL' sim.log && exit 1
grep -q '>>> PASS' sim.log || exit 1
exit 0

/* verification/tb_ice51.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ice51;

   localparam int CLKS_PER_BIT = 8;
   localparam int CODE_AW      = 6;
   localparam int CODE_SIZE    = 64;
   localparam int TIMEOUT      = 3000;   // cycles

   logic               i_clk = 1'b0;
   logic               i_nrst;
   logic               i_uart_rx;
   logic               o_uart_tx;
   logic               o_code_wr;
   logic [CODE_AW-1:0] o_code_addr;
   logic [7:0]         o_code_data;
   logic [7:0]         i_code_data = '0;

   logic [7:0] code_mem [CODE_SIZE];
   logic [7:0] image [CODE_SIZE];
   logic [7:0] rx_q [$];
   logic [7:0] exp_q [$];
   int         pos;
   int         wr_count;
   int         errors;
   int         checks;
   int         tests_run;
   int         tests_failed;
   int         frames;
   int         frame_errs;

   ice51_top #(
      .CLKS_PER_BIT (CLKS_PER_BIT),
      .CODE_AW      (CODE_AW)
   ) i_dut (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_uart_rx   (i_uart_rx),
      .o_uart_tx   (o_uart_tx),
      .o_code_wr   (o_code_wr),
      .o_code_addr (o_code_addr),
      .o_code_data (o_code_data),
      .i_code_data (i_code_data)
   );

   always #2 i_clk = ~i_clk;

   // code ram with a registered read
   always @(posedge i_clk) begin
      if (o_code_wr) code_mem[o_code_addr] <= o_code_data;
      i_code_data <= code_mem[o_code_addr];
   end

   task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   // every write goes to the next byte index
   always @(negedge i_clk) begin
      if (i_nrst && o_code_wr) begin
         check("o_code_addr", 16'(o_code_addr), 16'(wr_count % CODE_SIZE));
         check("o_code_data", 16'(o_code_data), 16'(image[wr_count % CODE_SIZE]));
         wr_count++;
      end
   end

   //////////////////////////////////////////////////
   // uart monitor samples once per cycle
   initial begin : uart_monitor
      logic [7:0] data;
      logic       bitv;
      int         err0;
      forever begin
         @(negedge i_clk);
         if (i_nrst && !o_uart_tx) begin
            err0 = errors;
            for (int b = 0; b < 10; b++) begin
               for (int c = 0; c < CLKS_PER_BIT; c++) begin
                  if (b > 0 || c > 0) @(negedge i_clk);
                  if (b == 0)      bitv = 1'b0;        // start
                  else if (b == 9) bitv = 1'b1;        // stop
                  else if (c == 0) begin
                     bitv = o_uart_tx;
                     data[b-1] = o_uart_tx;            // lsb first
                  end
                  check("o_uart_tx", 16'(o_uart_tx), 16'(bitv));
               end
            end
            frames++;
            if (errors != err0) frame_errs++;
            rx_q.push_back(data);
         end
      end
   end

   //////////////////////////////////////////////////
   // small assembler
   function automatic logic [3:0] hex_nibble(input logic [7:0] ch);
      if (ch >= 8'h61) return 4'(ch - 8'h57);
      if (ch >= 8'h41) return 4'(ch - 8'h37);
      return 4'(ch - 8'h30);
   endfunction

   task automatic new_image;
      for (int a = 0; a < CODE_SIZE; a++) image[a] = 8'($urandom);
      pos = 3;
      exp_q.delete();
   endtask

   task automatic put(input string s);
      int i;
      i = 0;
      while (i < s.len()) begin
         if (s.getc(i) == 8'h20) begin
            i++;
         end else begin
            image[pos] = {hex_nibble(s.getc(i)), hex_nibble(s.getc(i + 1))};
            pos++;
            i += 2;
         end
      end
   endtask

   // offset counts from the next instruction
   task automatic put_rel(input logic [7:0] op, input int target);
      image[pos]     = op;
      image[pos + 1] = 8'(target - (pos + 2));
      pos += 2;
   endtask

   task automatic put_cjne(input int rn, input logic [7:0] imm, input int target);
      image[pos]     = 8'hB8 | 8'(rn);
      image[pos + 1] = imm;
      image[pos + 2] = 8'(target - (pos + 3));
      pos += 3;
   endtask

   // sends acc over the uart and uses r7 and dptr
   task automatic put_send;
      int poll;
      put("FF 90 02 00");
      poll = pos;
      put("E0");
      put_rel(8'h70, poll);
      put("EF 90 02 01 F0");
   endtask

   task automatic put_halt;
      put_rel(8'h80, pos);
      if (pos > CODE_SIZE) begin
         $display("program does not fit into the code ram");
         errors++;
      end
   endtask

   //////////////////////////////////////////////////
   // reference arithmetic on whole numbers

   // carry is set when the true sum passes 255
   function automatic logic [8:0] add_with_carry(input logic [7:0] x, input logic [7:0] y);
      int s;
      s = int'(x) + int'(y);
      return {s > 255, 8'(s)};
   endfunction

   // carry flags a result below zero
   function automatic logic [8:0] subb_with_borrow(input logic [7:0] x, input logic [7:0] y,
                                                   input logic cin);
      int d;
      d = int'(x) - int'(y) - int'(cin);
      return {d < 0, 8'(d)};
   endfunction

   //////////////////////////////////////////////////
   // run control
   task automatic finish_run;
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) $display(">>> PASS");
      else $display(">>> FAIL");
      $finish;
   endtask

   task automatic end_test(input string name, input int err0);
      tests_run++;
      if (errors == err0) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - err0);
      end
   endtask

   task automatic send_bit(input logic v);
      i_uart_rx = v;
      repeat (CLKS_PER_BIT) @(negedge i_clk);
   endtask

   task automatic send_byte(input logic [7:0] d);
      send_bit(1'b0);
      for (int i = 0; i < 8; i++) send_bit(d[i]);
      send_bit(1'b1);
   endtask

   task automatic load_image;
      int t;
      i_nrst = 1'b0;
      wr_count = 0;
      rx_q.delete();
      repeat (10) @(negedge i_clk);
      i_nrst = 1'b1;
      for (int a = 0; a < CODE_SIZE; a++) send_byte(image[a]);
      t = 0;
      while (wr_count < CODE_SIZE && t < TIMEOUT) begin
         @(negedge i_clk);
         t++;
      end
      if (wr_count < CODE_SIZE) begin
         $display("timeout, only %0d code bytes were written", wr_count);
         errors++;
         finish_run();
      end
   endtask

   task automatic expect_rx;
      int t;
      t = 0;
      while (rx_q.size() < exp_q.size() && t < TIMEOUT) begin
         @(negedge i_clk);
         t++;
      end
      if (rx_q.size() < exp_q.size()) begin
         $display("timeout, %0d of %0d uart bytes arrived", rx_q.size(), exp_q.size());
         errors++;
         finish_run();
      end
      repeat (30 * CLKS_PER_BIT) @(negedge i_clk);   // nothing more may follow
      check("uart byte count", 16'(rx_q.size()), 16'(exp_q.size()));
      foreach (exp_q[i]) check($sformatf("uart byte %0d", i), 16'(rx_q[i]), 16'(exp_q[i]));
   endtask

   //////////////////////////////////////////////////
   // tests
   task automatic test_loading;
      int err0;
      err0 = errors;
      new_image();
      put_halt();
      load_image();
      send_byte(8'hA5);                          // one byte past the image
      repeat (2 * CLKS_PER_BIT) @(negedge i_clk);
      check("code write count", 16'(wr_count), 16'(CODE_SIZE));
      for (int a = 0; a < CODE_SIZE; a++) begin
         check($sformatf("code_mem[%0d]", a), 16'(code_mem[a]), 16'(image[a]));
      end
      end_test("loading", err0);
   endtask

   task automatic test_arith;
      int         err0;
      logic [7:0] a;
      logic       c;
      err0 = errors;
      new_image();
      put("74 5A");
      put_send();
      put("24 C3");
      put_send();
      put("94 10");
      put_send();
      put("94 20");
      put_send();
      put_halt();
      a = 8'h5A;
      exp_q.push_back(a);
      {c, a} = add_with_carry(a, 8'hC3);
      exp_q.push_back(a);
      {c, a} = subb_with_borrow(a, 8'h10, c);    // borrow in
      exp_q.push_back(a);
      {c, a} = subb_with_borrow(a, 8'h20, c);    // borrow out
      exp_q.push_back(a);
      load_image();
      expect_rx();
      new_image();
      put("74 3C 64 A5 F4 04");   // mov, xrl, cpl, inc
      put_send();
      put("E4 14");               // clr, dec
      put_send();
      put("7A 11 2A 9A");         // r2 forms of add and subb
      put_send();
      put_halt();
      a = ~(8'h3C ^ 8'hA5) + 8'd1;
      exp_q.push_back(a);
      a = 8'h00 - 8'd1;
      exp_q.push_back(a);
      {c, a} = add_with_carry(a, 8'h11);
      {c, a} = subb_with_borrow(a, 8'h11, c);
      exp_q.push_back(a);
      load_image();
      expect_rx();
      end_test("arithmetic", err0);
   endtask

   task automatic test_branches;
      int         err0;
      int         lbl;
      int         n;
      logic [7:0] a;
      logic       c;
      err0 = errors;
      new_image();
      put("79 00");
      lbl = pos;
      put("09");
      put_cjne(1, 8'h05, lbl);
      put("E9");
      put_send();
      put("74 03 7A 00");
      lbl = pos;
      put("0A 14");
      put_rel(8'h70, lbl);        // jnz
      put("EA");
      put_send();
      put_halt();
      n = 0;
      do n++; while (n != 5);
      exp_q.push_back(8'(n));
      n = 0;
      a = 8'h03;
      do begin
         n++;
         a--;
      end while (a != 0);
      exp_q.push_back(8'(n));
      load_image();
      expect_rx();
      new_image();
      put("7C 00");
      lbl = pos;
      put("0C");
      put_cjne(4, 8'h03, pos + 3);   // only for the carry
      put_rel(8'h40, lbl);           // jc
      put("EC");
      put_send();
      put("C3 74 02 7B 00");
      lbl = pos;
      put("0B 94 01");
      put_rel(8'h50, lbl);           // jnc
      put("EB");
      put_send();
      put_halt();
      n = 0;
      do begin
         n++;
         c = (n < 3);
      end while (c);
      exp_q.push_back(8'(n));
      n = 0;
      a = 8'h02;
      c = 1'b0;
      do begin
         n++;
         {c, a} = subb_with_borrow(a, 8'h01, c);
      end while (!c);
      exp_q.push_back(8'(n));
      load_image();
      expect_rx();
      new_image();
      put("7D 00");
      lbl = pos;
      put("0D ED 64 04");
      put_rel(8'h60, pos + 4);       // jz over the sjmp
      put_rel(8'h80, lbl);           // backward sjmp
      put("ED");
      put_send();
      put_halt();
      n = 0;
      do n++; while ((n ^ 4) != 0);
      exp_q.push_back(8'(n));
      load_image();
      expect_rx();
      end_test("branches", err0);
   endtask

   task automatic test_busy;
      int err0;
      err0 = errors;
      new_image();
      for (int i = 0; i < 4; i++) begin
         put($sformatf("74 %02x", 8'hA1 + 8'(i * 8'h11)));
         put_send();
         exp_q.push_back(8'hA1 + 8'(i * 8'h11));
      end
      put_halt();
      load_image();
      expect_rx();
      end_test("busy polling", err0);
   endtask

   task automatic test_format;
      int err0;
      err0 = errors;
      if (frames == 0) begin
         $display("no uart frame was seen");
         errors++;
      end
      check("bad frame count", 16'(frame_errs), 16'd0);
      end_test($sformatf("serial format, %0d frames", frames), err0);
   endtask

   initial begin
      void'($urandom(10));
      i_nrst       = 1'b0;
      i_uart_rx    = 1'b1;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      frames       = 0;
      frame_errs   = 0;
      wr_count     = 0;
      test_loading();
      test_arith();
      test_branches();
      test_busy();
      test_format();
      finish_run();
   end

endmodule

`default_nettype wire

/* design/ice51_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ice51_top #(
   parameter int CLKS_PER_BIT = 104,
   parameter int CODE_AW      = 9
) (
   input  wire                 i_clk,
   input  wire                 i_nrst,
   input  wire                 i_uart_rx,
   output logic                o_uart_tx,
   output logic                o_code_wr,
   output logic [CODE_AW-1:0]  o_code_addr,
   output ice51_pkg::byte_t    o_code_data,
   input  wire                 ice51_pkg::byte_t i_code_data
);
   import ice51_pkg::*;

   logic               rx_valid;
   byte_t              rx_byte;
   logic [CODE_AW-1:0] ld_addr;
   logic               load_done;
   logic [CODE_AW-1:0] fetch_addr;
   logic               tx_start;
   byte_t              tx_byte;
   logic               tx_busy;

   exec_if ex_bus ();

   uart_rx_loader #(
      .CLKS_PER_BIT (CLKS_PER_BIT),
      .CODE_AW      (CODE_AW)
   ) u_loader (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_rx         (i_uart_rx),
      .o_byte_valid (rx_valid),
      .o_byte       (rx_byte),
      .o_addr       (ld_addr),
      .o_load_done  (load_done)
   );

   cpu_sequencer #(.CODE_AW(CODE_AW)) u_seq (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_load_done  (load_done),
      .i_code_data  (i_code_data),
      .o_fetch_addr (fetch_addr),
      .ex           (ex_bus.seq)
   );

   cpu_datapath u_dp (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_tx_busy    (tx_busy),
      .o_tx_start   (tx_start),
      .o_tx_byte    (tx_byte),
      .ex           (ex_bus.dp)
   );

   uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_start      (tx_start),
      .i_byte       (tx_byte),
      .o_busy       (tx_busy),
      .o_tx         (o_uart_tx)
   );

   // loader owns the ram port until the image is in
   assign o_code_wr   = rx_valid & ~load_done;
   assign o_code_addr = load_done ? fetch_addr : ld_addr;
   assign o_code_data = rx_byte;

endmodule

`default_nettype wire

/* design/cpu_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath (
   input  wire                 i_clk,
   input  wire                 i_nrst,
   input  wire                 i_tx_busy,
   output logic                o_tx_start,
   output ice51_pkg::byte_t    o_tx_byte,
   exec_if.dp                  ex
);
   import ice51_pkg::*;

   byte_t      acc;
   byte_t      acc_next;
   byte_t      r [8];         // r0..r7
   byte_t      r_sel;
   reg_idx_t   ridx;
   logic       carry;
   logic       carry_next;
   word_t      dptr;
   byte_t      add_opnd;
   byte_t      sub_opnd;
   logic [8:0] sum;
   logic [8:0] diff;
   logic       op_addar, op_subbar, op_movar, op_movra;
   logic       op_movri, op_incr, op_decr, op_cjne;
   logic       movx_tx, movx_stat;
   logic       cond;

   assign op_addar  = op_is_rform(ex.op, OP_ADDAR);
   assign op_subbar = op_is_rform(ex.op, OP_SUBBAR);
   assign op_movar  = op_is_rform(ex.op, OP_MOVAR);
   assign op_movra  = op_is_rform(ex.op, OP_MOVRA);
   assign op_movri  = op_is_rform(ex.op, OP_MOVRI);
   assign op_incr   = op_is_rform(ex.op, OP_INCR);
   assign op_decr   = op_is_rform(ex.op, OP_DECR);
   assign op_cjne   = op_is_rform(ex.op, OP_CJNERI);

   assign ridx  = ex.op[2:0];
   assign r_sel = r[ridx];

   //////////////////////////////////////////////////
   // alu
   assign add_opnd = op_addar  ? r_sel : ex.opd1;
   assign sub_opnd = op_subbar ? r_sel : ex.opd1;
   assign sum      = {1'b0, acc} + {1'b0, add_opnd};                   // bit 8 = carry out
   assign diff     = {1'b0, acc} - {1'b0, sub_opnd} - {8'd0, carry};   // bit 8 = borrow

   always_comb begin
      acc_next = acc;
      if (ex.op == OP_MOVAI)                       acc_next = ex.opd1;
      else if (op_movar)                           acc_next = r_sel;
      else if (ex.op == OP_ADDAI || op_addar)      acc_next = sum[7:0];
      else if (ex.op == OP_SUBBAI || op_subbar)    acc_next = diff[7:0];
      else if (ex.op == OP_XRLAI)                  acc_next = acc ^ ex.opd1;
      else if (ex.op == OP_INCA)                   acc_next = acc + 8'd1;
      else if (ex.op == OP_DECA)                   acc_next = acc - 8'd1;
      else if (ex.op == OP_CLRA)                   acc_next = '0;
      else if (ex.op == OP_CPLA)                   acc_next = ~acc;
      else if (movx_stat)                          acc_next = {7'd0, i_tx_busy};
   end

   always_comb begin
      carry_next = carry;
      if (ex.op == OP_ADDAI || op_addar)           carry_next = sum[8];
      else if (ex.op == OP_SUBBAI || op_subbar)    carry_next = diff[8];
      else if (op_cjne)                            carry_next = (r_sel < ex.opd1);
      else if (ex.op == OP_CLRC)                   carry_next = 1'b0;
      else if (ex.op == OP_SETBC)                  carry_next = 1'b1;
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
      end else if (ex.exec) begin
         acc   <= acc_next;
         carry <= carry_next;
         if (ex.op == OP_MOVDP) dptr <= {ex.opd1, ex.opd2};
      end
   end

   // register bank
   always_ff @(posedge i_clk) begin
      if (ex.exec) begin
         if (op_movri)        r[ridx] <= ex.opd1;
         else if (op_movra)   r[ridx] <= acc;
         else if (op_incr)    r[ridx] <= r_sel + 8'd1;
         else if (op_decr)    r[ridx] <= r_sel - 8'd1;
      end
   end

   //////////////////////////////////////////////////
   // branch decision, sjmp always taken
   always_comb begin
      cond = 1'b0;
      if (ex.op == OP_SJMP)       cond = 1'b1;
      else if (ex.op == OP_JC)    cond = carry;
      else if (ex.op == OP_JNC)   cond = ~carry;
      else if (ex.op == OP_JZ)    cond = (acc == 8'd0);
      else if (ex.op == OP_JNZ)   cond = (acc != 8'd0);
      else if (op_cjne)           cond = (r_sel != ex.opd1);
   end

   assign ex.take_branch = ex.exec & cond;

   // uart sits in xdata space
   assign movx_tx    = (ex.op == OP_MOVXDA) && (dptr == UART_TX_ADDR);
   assign movx_stat  = (ex.op == OP_MOVXAD) && (dptr == UART_STAT_ADDR);
   assign o_tx_start = ex.exec & movx_tx;
   assign o_tx_byte  = acc;

endmodule

`default_nettype wire

/* design/cpu_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer #(
   parameter int CODE_AW = 9
) (
   input  wire                 i_clk,
   input  wire                 i_nrst,
   input  wire                 i_load_done,
   input  wire                 ice51_pkg::byte_t i_code_data,
   output logic [CODE_AW-1:0]  o_fetch_addr,
   exec_if.seq                 ex
);
   import ice51_pkg::*;

   cpu_state_t         state;
   logic [CODE_AW-1:0] pc;
   logic [CODE_AW-1:0] pc_exec;
   logic [1:0]         n_opd;       // operand bytes after the opcode
   byte_t              rel;
   word_t              br_target;
   word_t              jmp_target;

   function automatic logic [1:0] opd_count(input byte_t op);
      if (op == OP_LJMP || op == OP_MOVDP || op_is_rform(op, OP_CJNERI)) begin
         return 2'd2;
      end
      if (op == OP_SJMP || op == OP_JC || op == OP_JNC || op == OP_JZ ||
          op == OP_JNZ || op == OP_MOVAI || op == OP_ADDAI || op == OP_SUBBAI ||
          op == OP_XRLAI || op_is_rform(op, OP_MOVRI)) begin
         return 2'd1;
      end
      return 2'd0;
   endfunction

   // opcode is still on the ram bus in DECODE0
   assign n_opd = opd_count((state == DECODE0) ? i_code_data : ex.op);

   //////////////////////////////////////////////////
   // state and program counter
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= FETCH;
         pc    <= CODE_AW'(RESET_PC);
      end else begin
         case (state)
            FETCH: if (i_load_done) begin
               state <= DECODE0;
               pc    <= pc + 1'b1;
            end
            DECODE0: begin
               if (n_opd == 2'd0) begin
                  state <= EXECUTE;
               end else begin
                  state <= DECODE1;
                  pc    <= pc + 1'b1;
               end
            end
            DECODE1: begin
               if (n_opd == 2'd2) begin
                  state <= DECODE2;
                  pc    <= pc + 1'b1;
               end else begin
                  state <= EXECUTE;
               end
            end
            DECODE2: state <= EXECUTE;
            EXECUTE: begin
               state <= FETCH;
               pc    <= pc_exec;
            end
            default: state <= FETCH;
         endcase
      end
   end

   // instruction bytes, one cycle behind their address
   always_ff @(posedge i_clk) begin
      if (state == DECODE0) ex.op   <= i_code_data;
      if (state == DECODE1) ex.opd1 <= i_code_data;
      if (state == DECODE2) ex.opd2 <= i_code_data;
   end

   //////////////////////////////////////////////////
   // jump targets
   assign rel        = op_is_rform(ex.op, OP_CJNERI) ? ex.opd2 : ex.opd1;
   assign br_target  = ex.next_pc + {{8{rel[7]}}, rel};   // 8051 rule
   assign jmp_target = {ex.opd1, ex.opd2};                // high byte first

   always_comb begin
      if (ex.op == OP_LJMP)      pc_exec = jmp_target[CODE_AW-1:0];
      else if (ex.take_branch)   pc_exec = br_target[CODE_AW-1:0];
      else                       pc_exec = pc;
   end

   assign ex.exec      = (state == EXECUTE);
   assign ex.next_pc   = word_t'(pc);   // pc already past the last operand here
   assign o_fetch_addr = pc;

endmodule

`default_nettype wire

/* design/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
   parameter int CLKS_PER_BIT = 104
) (
   input  wire               i_clk,
   input  wire               i_nrst,
   input  wire               i_start,
   input  wire               ice51_pkg::byte_t i_byte,
   output logic              o_busy,
   output logic              o_tx
);
   import ice51_pkg::*;

   localparam int               CNT_W    = $clog2(CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(CLKS_PER_BIT - 1);

   tx_state_t        state;
   logic [CNT_W-1:0] cnt;
   logic [3:0]       bit_cnt;     // 0..7 data, 8 stop
   byte_t            shreg;
   logic             bit_end;

   assign bit_end = (cnt == FULL_CNT);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_cnt <= '0;
      end else begin
         cnt <= cnt + 1'b1;
         case (state)
            TX_IDLE: begin
               cnt <= '0;
               if (i_start) state <= TX_START;   // start while busy never reaches here
            end
            TX_START: if (bit_end) begin
               cnt     <= '0;
               bit_cnt <= '0;
               state   <= TX_SEND;
            end
            TX_SEND: if (bit_end) begin
               cnt     <= '0;
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == 4'd8) state <= TX_IDLE;
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   // shift right, ones fill in behind for the stop bit
   always_ff @(posedge i_clk) begin
      if (state == TX_IDLE && i_start)        shreg <= i_byte;
      else if (state == TX_SEND && bit_end)   shreg <= {1'b1, shreg[7:1]};
   end

   assign o_busy = (state != TX_IDLE);
   assign o_tx   = (state == TX_START) ? 1'b0 :
                   (state == TX_SEND)  ? shreg[0] :
                                         1'b1;

endmodule

`default_nettype wire

/* design/uart_rx_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_loader #(
   parameter int CLKS_PER_BIT = 104,
   parameter int CODE_AW      = 9
) (
   input  wire                 i_clk,
   input  wire                 i_nrst,
   input  wire                 i_rx,
   output logic                o_byte_valid,
   output ice51_pkg::byte_t    o_byte,
   output logic [CODE_AW-1:0]  o_addr,
   output logic                o_load_done
);
   import ice51_pkg::*;

   localparam int               CNT_W    = $clog2(CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(CLKS_PER_BIT - 1);

   logic             rx_meta;
   logic             rx_sync;
   rx_state_t        state;
   logic [CNT_W-1:0] cnt;
   logic [2:0]       bit_cnt;

   // line idles high
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
      end
   end

   //////////////////////////////////////////////////
   // frame timing, sample at bit middles
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state        <= RX_IDLE;
         cnt          <= '0;
         bit_cnt      <= '0;
         o_byte_valid <= 1'b0;
      end else begin
         o_byte_valid <= 1'b0;
         cnt          <= cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx_sync) state <= RX_START;
            end
            RX_START: if (cnt == HALF_CNT) begin
               cnt     <= '0;
               bit_cnt <= '0;
               if (rx_sync) state <= RX_IDLE;   // glitch, not a start bit
               else         state <= RX_DATA;
            end
            RX_DATA: if (cnt == FULL_CNT) begin
               cnt     <= '0;
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == 3'd7) state <= RX_STOP;
            end
            RX_STOP: if (cnt == FULL_CNT) begin
               o_byte_valid <= 1'b1;             // one cycle after stop sample
               state        <= RX_IDLE;
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // lsb arrives first
   always_ff @(posedge i_clk) begin
      if (state == RX_DATA && cnt == FULL_CNT) o_byte <= {rx_sync, o_byte[7:1]};
   end

   //////////////////////////////////////////////////
   // image address counter
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_addr      <= '0;
         o_load_done <= 1'b0;
      end else if (o_byte_valid && !o_load_done) begin
         o_addr <= o_addr + 1'b1;
         if (&o_addr) o_load_done <= 1'b1;   // counter wraps to zero
      end
   end

endmodule

`default_nettype wire

/* design/exec_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface exec_if;
   import ice51_pkg::*;

   byte_t op;           // latched opcode
   byte_t opd1;         // first operand byte
   byte_t opd2;
   logic  exec;         // one cycle, EXECUTE state
   word_t next_pc;      // address after the current instruction
   logic  take_branch;

   // sequencer owns the instruction, datapath owns the condition
   modport seq (output op, output opd1, output opd2, output exec, output next_pc,
                input take_branch);
   modport dp  (input op, input opd1, input opd2, input exec,
                output take_branch);

endinterface

`default_nettype wire

/* design/ice51_pkg.sv */
`default_nettype none

package ice51_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;  // r0..r7

   // register forms keep rN in bits 2:0
   typedef enum logic [7:0] {
      OP_LJMP   = 8'h02,   // ljmp addr16
      OP_INCA   = 8'h04,
      OP_INCR   = 8'h08,   // inc rN
      OP_DECA   = 8'h14,
      OP_DECR   = 8'h18,   // dec rN
      OP_ADDAI  = 8'h24,   // add a,#imm
      OP_ADDAR  = 8'h28,   // add a,rN
      OP_JC     = 8'h40,
      OP_JNC    = 8'h50,
      OP_JZ     = 8'h60,
      OP_XRLAI  = 8'h64,   // xrl a,#imm
      OP_JNZ    = 8'h70,
      OP_MOVAI  = 8'h74,   // mov a,#imm
      OP_MOVRI  = 8'h78,   // mov rN,#imm
      OP_SJMP   = 8'h80,
      OP_MOVDP  = 8'h90,   // mov dptr,#imm16
      OP_SUBBAI = 8'h94,
      OP_SUBBAR = 8'h98,
      OP_CJNERI = 8'hB8,   // cjne rN,#imm,rel
      OP_CLRC   = 8'hC3,
      OP_SETBC  = 8'hD3,
      OP_MOVXAD = 8'hE0,   // movx a,@dptr
      OP_CLRA   = 8'hE4,
      OP_MOVAR  = 8'hE8,   // mov a,rN
      OP_MOVXDA = 8'hF0,   // movx @dptr,a
      OP_CPLA   = 8'hF4,
      OP_MOVRA  = 8'hF8    // mov rN,a
   } opcode_t;

   typedef enum logic [2:0] {FETCH, DECODE0, DECODE1, DECODE2, EXECUTE} cpu_state_t;
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_t;

   localparam word_t RESET_PC       = 16'h0003;
   localparam word_t UART_STAT_ADDR = 16'h0200;  // bit 0 = tx busy
   localparam word_t UART_TX_ADDR   = 16'h0201;

   // match on the top five opcode bits
   function automatic logic op_is_rform(input byte_t op, input opcode_t base);
      return op[7:3] == base[7:3];
   endfunction

endpackage

`default_nettype wire
